/* hdl/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;  // data and address width.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instructions known to the decoder.
    typedef enum logic [4:0] {
        inst_auipc,
        inst_jal,
        inst_jalr,
        inst_beq,
        inst_bne,
        inst_lw,
        inst_lbu,
        inst_sh,
        inst_sw,
        inst_addi,
        inst_sltiu,
        inst_srai,
        inst_add,
        inst_sub,
        inst_sltu,
        inst_xor,
        inst_or,
        inst_ebreak,
        inst_illegal  // anything outside the subset lands here.
    } inst_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encoding formats; fmt_n carries no immediate and never moves the pc.
    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_n
    } inst_fmt_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller phases.
    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_memory,
        st_halt
    } ctrl_state_e;

endpackage

/* hdl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  logic [rv_pkg::xlen-1:0] inst,
    output rv_pkg::inst_e           inst_num,
    output rv_pkg::inst_fmt_e       inst_type,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [4:0]              rd,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    always_comb begin
        inst_num  = inst_illegal;
        inst_type = fmt_n;
        case (opcode)
            7'b0010111: begin
                inst_num  = inst_auipc;
                inst_type = fmt_u;
            end
            7'b1101111: begin
                inst_num  = inst_jal;
                inst_type = fmt_j;
            end
            7'b1100111: begin
                if (funct3 == 3'b000) begin
                    inst_num  = inst_jalr;
                    inst_type = fmt_i;
                end
            end
            7'b1100011: begin
                if (funct3 == 3'b000) begin
                    inst_num  = inst_beq;
                    inst_type = fmt_b;
                end else if (funct3 == 3'b001) begin
                    inst_num  = inst_bne;
                    inst_type = fmt_b;
                end
            end
            7'b0000011: begin
                if (funct3 == 3'b010) begin
                    inst_num  = inst_lw;
                    inst_type = fmt_i;
                end else if (funct3 == 3'b100) begin
                    inst_num  = inst_lbu;
                    inst_type = fmt_i;
                end
            end
            7'b0100011: begin
                if (funct3 == 3'b001) begin
                    inst_num  = inst_sh;
                    inst_type = fmt_s;
                end else if (funct3 == 3'b010) begin
                    inst_num  = inst_sw;
                    inst_type = fmt_s;
                end
            end
            7'b0010011: begin
                if (funct3 == 3'b000) begin
                    inst_num  = inst_addi;
                    inst_type = fmt_i;
                end else if (funct3 == 3'b011) begin
                    inst_num  = inst_sltiu;
                    inst_type = fmt_i;
                end else if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
                    inst_num  = inst_srai;
                    inst_type = fmt_i;
                end
            end
            7'b0110011: begin
                inst_type = fmt_r;
                case ({funct7, funct3})
                    10'b0000000_000: inst_num = inst_add;
                    10'b0100000_000: inst_num = inst_sub;
                    10'b0000000_011: inst_num = inst_sltu;
                    10'b0000000_100: inst_num = inst_xor;
                    10'b0000000_110: inst_num = inst_or;
                    default:         inst_type = fmt_n;  // unknown alu op halts.
                endcase
            end
            7'b1110011: begin
                if (inst == 32'h0010_0073) begin
                    inst_num = inst_ebreak;
                end
            end
            default: inst_num = inst_illegal;
        endcase
    end

    // immediates are sign extended from bit 31 in every layout except u.
    always_comb begin
        case (inst_type)
            fmt_i:   imm = {{20{inst[31]}}, inst[31:20]};
            fmt_s:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            fmt_b:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u:   imm = {inst[31:12], 12'b0};
            fmt_j:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic [rv_pkg::xlen-1:0] rd_data,
    input  logic                    rd_w_en,
    output logic [rv_pkg::xlen-1:0] src1,
    output logic [rv_pkg::xlen-1:0] src2
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1:31];  // x0 has no storage.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_w_en && (rd != 5'd0)) begin
            regs[rd] <= rd_data;
        end
    end

    assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* hdl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::inst_e           inst_num,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] src1,
    input  logic [rv_pkg::xlen-1:0] src2,
    input  logic [rv_pkg::xlen-1:0] imm,
    output logic [rv_pkg::xlen-1:0] alu_result
);
    import rv_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;

    always_comb begin
        op_a = src1;
        case (inst_num)
            inst_auipc, inst_jal, inst_jalr: op_a = pc;
            default:                         op_a = src1;
        endcase
    end

    always_comb begin
        case (inst_num)
            inst_jal, inst_jalr: op_b = 32'd4;  // link value is pc plus 4.
            inst_auipc, inst_addi, inst_sltiu, inst_srai,
            inst_lw, inst_lbu, inst_sh, inst_sw: op_b = imm;
            default:                             op_b = src2;
        endcase
    end

    always_comb begin
        case (inst_num)
            inst_auipc, inst_jal, inst_jalr, inst_addi, inst_add,
            inst_lw, inst_lbu, inst_sh, inst_sw: alu_result = op_a + op_b;
            inst_sub:               alu_result = op_a - op_b;
            inst_sltiu, inst_sltu:  alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
            inst_srai:              alu_result = $signed(op_a) >>> op_b[4:0];
            inst_xor:               alu_result = op_a ^ op_b;
            inst_or:                alu_result = op_a | op_b;
            // bit 0 carries the taken flag for the next-pc unit.
            inst_beq:               alu_result = {{(xlen-1){1'b0}}, op_a == op_b};
            inst_bne:               alu_result = {{(xlen-1){1'b0}}, op_a != op_b};
            default:                alu_result = '0;
        endcase
    end

endmodule

/* hdl/rv_next_pc.sv */
`timescale 1ns/1ps

module rv_next_pc (
    input  rv_pkg::inst_e           inst_num,
    input  rv_pkg::inst_fmt_e       inst_type,
    input  logic [rv_pkg::xlen-1:0] imm,
    input  logic [rv_pkg::xlen-1:0] pc_out,
    input  logic [rv_pkg::xlen-1:0] src1,
    input  logic [rv_pkg::xlen-1:0] alu_result,
    output logic [rv_pkg::xlen-1:0] pc_in,
    output logic                    pc_w_en
);
    import rv_pkg::*;

    localparam logic [xlen-1:0] step = 32'd4;

    logic [xlen-1:0] adder_a;
    logic [xlen-1:0] adder_b;
    logic [xlen-1:0] adder_s;

    always_comb begin
        case (inst_num)
            inst_jalr: adder_a = src1;
            default:   adder_a = pc_out;
        endcase
    end

    always_comb begin
        case (inst_num)
            inst_jal, inst_jalr: adder_b = imm;
            inst_beq, inst_bne:  adder_b = alu_result[0] ? imm : step;
            default:             adder_b = step;
        endcase
    end

    assign adder_s = adder_a + adder_b;

    // jalr targets drop bit 0, every other target keeps it.
    assign pc_in = {adder_s[xlen-1:1], adder_s[0] & (inst_num != inst_jalr)};

    always_comb begin
        case (inst_type)
            fmt_n:   pc_w_en = 1'b0;  // ebreak and illegal freeze the pc.
            default: pc_w_en = 1'b1;
        endcase
    end

endmodule

/* hdl/rv_bus_ctrl.sv */
`timescale 1ns/1ps

module rv_bus_ctrl #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [rv_pkg::xlen-1:0] wb_adr,
    output logic [rv_pkg::xlen-1:0] wb_wdata,
    output logic [3:0]              wb_sel,
    output logic                    wb_we,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    input  logic [rv_pkg::xlen-1:0] wb_rdata,
    input  logic                    wb_ack,
    output logic                    halted,
    output logic [rv_pkg::xlen-1:0] inst,
    output logic [rv_pkg::xlen-1:0] pc,
    input  rv_pkg::inst_e           inst_num,
    input  rv_pkg::inst_fmt_e       inst_type,
    input  logic [4:0]              rd,
    input  logic [rv_pkg::xlen-1:0] src2,
    input  logic [rv_pkg::xlen-1:0] alu_result,
    input  logic [rv_pkg::xlen-1:0] pc_next,
    input  logic                    pc_w_en,
    output logic [rv_pkg::xlen-1:0] rd_data,
    output logic                    rd_w_en
);
    import rv_pkg::*;

    ctrl_state_e     state;
    logic            req;
    logic            is_load;
    logic            is_store;
    logic            writes_rd;
    logic [7:0]      load_byte;
    logic [xlen-1:0] load_data;

    assign is_load   = (inst_num == inst_lw) || (inst_num == inst_lbu);
    assign is_store  = (inst_type == fmt_s);
    assign writes_rd = (inst_type == fmt_r) || (inst_type == fmt_i) ||
                       (inst_type == fmt_u) || (inst_type == fmt_j);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencing. req stays high from the start of a transfer until its ack.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_fetch;
            pc    <= reset_pc;
            req   <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (!req) begin
                        req <= 1'b1;
                    end else if (wb_ack) begin
                        req   <= 1'b0;
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    if (inst_type == fmt_n) begin
                        state <= st_halt;
                    end else if (is_load || is_store) begin
                        req   <= 1'b1;
                        state <= st_memory;
                    end else begin
                        if (pc_w_en) begin
                            pc <= pc_next;
                        end
                        req   <= 1'b1;  // the idle execute cycle is the bus gap.
                        state <= st_fetch;
                    end
                end
                st_memory: begin
                    if (wb_ack) begin
                        if (pc_w_en) begin
                            pc <= pc_next;
                        end
                        req   <= 1'b0;
                        state <= st_fetch;
                    end
                end
                default: state <= st_halt;  // halt holds until reset.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && req && wb_ack) begin
            inst <= wb_rdata;
        end
    end

    assign halted = (state == st_halt);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus drive. address and lanes come from held registers, so they are stable.
    assign wb_cyc = req;
    assign wb_stb = req;
    assign wb_we  = (state == st_memory) && is_store;
    assign wb_adr = (state == st_memory) ? alu_result : pc;

    always_comb begin
        wb_sel   = 4'b1111;
        wb_wdata = src2;
        if (state == st_memory && inst_num == inst_sh) begin
            wb_sel   = alu_result[1] ? 4'b1100 : 4'b0011;
            wb_wdata = {2{src2[15:0]}};  // the slave picks the half it needs.
        end
    end

    // load extraction and write-back.
    always_comb begin
        case (alu_result[1:0])
            2'd0:    load_byte = wb_rdata[7:0];
            2'd1:    load_byte = wb_rdata[15:8];
            2'd2:    load_byte = wb_rdata[23:16];
            default: load_byte = wb_rdata[31:24];
        endcase
        load_data = (inst_num == inst_lbu) ? {{(xlen-8){1'b0}}, load_byte} : wb_rdata;
    end

    assign rd_data = is_load ? load_data : alu_result;
    assign rd_w_en = writes_rd && (rd != 5'd0) &&
                     ((state == st_execute && !is_load) ||
                      (state == st_memory && is_load && wb_ack));

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [rv_pkg::xlen-1:0] wb_adr,
    output logic [rv_pkg::xlen-1:0] wb_wdata,
    output logic [3:0]              wb_sel,
    output logic                    wb_we,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    input  logic [rv_pkg::xlen-1:0] wb_rdata,
    input  logic                    wb_ack,
    output logic                    halted
);
    import rv_pkg::*;

    logic [xlen-1:0] inst;
    logic [xlen-1:0] pc;
    inst_e           inst_num;
    inst_fmt_e       inst_type;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] pc_next;
    logic            pc_w_en;
    logic [xlen-1:0] rd_data;
    logic            rd_w_en;

    rv_bus_ctrl #(
        .reset_pc(reset_pc)
    ) i_bus_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_sel    (wb_sel),
        .wb_we     (wb_we),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .halted    (halted),
        .inst      (inst),
        .pc        (pc),
        .inst_num  (inst_num),
        .inst_type (inst_type),
        .rd        (rd),
        .src2      (src2),
        .alu_result(alu_result),
        .pc_next   (pc_next),
        .pc_w_en   (pc_w_en),
        .rd_data   (rd_data),
        .rd_w_en   (rd_w_en)
    );

    rv_decoder i_decoder (
        .inst     (inst),
        .inst_num (inst_num),
        .inst_type(inst_type),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm)
    );

    rv_regfile i_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .rd_data(rd_data),
        .rd_w_en(rd_w_en),
        .src1   (src1),
        .src2   (src2)
    );

    rv_alu i_alu (
        .inst_num  (inst_num),
        .pc        (pc),
        .src1      (src1),
        .src2      (src2),
        .imm       (imm),
        .alu_result(alu_result)
    );

    rv_next_pc i_next_pc (
        .inst_num  (inst_num),
        .inst_type (inst_type),
        .imm       (imm),
        .pc_out    (pc),
        .src1      (src1),
        .alu_result(alu_result),
        .pc_in     (pc_next),
        .pc_w_en   (pc_w_en)
    );

endmodule

/* verification/rv_core_checker.sv */
`timescale 1ns/1ps

module rv_core_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        active,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_wdata,
    input  logic [3:0]  wb_sel,
    input  logic        wb_we,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_ack,
    input  logic        halted,
    input  logic [31:0] exp_adr [0:7],
    input  logic [31:0] exp_data [0:7],
    input  logic [3:0]  exp_sel [0:7],
    input  int          exp_count,
    input  logic        exp_halt,
    output int          error_count
);

    int   errors = 0;
    int   store_count = 0;
    logic halt_seen = 1'b0;
    logic active_q = 1'b0;

    assign error_count = errors;

    // byte lanes that a select mask enables.
    function automatic logic [31:0] lane_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // a write completes in the cycle where stb and ack are both high.
    always @(posedge clk) begin
        if (!rst_n) begin
            store_count <= 0;
            halt_seen   <= 1'b0;
        end else if (active) begin
            if (wb_cyc && wb_stb && wb_we && wb_ack) begin
                if (store_count < exp_count) begin
                    compare("wb_adr", wb_adr, exp_adr[store_count]);
                    compare("wb_sel", {28'd0, wb_sel}, {28'd0, exp_sel[store_count]});
                    compare("wb_wdata", wb_wdata & lane_mask(exp_sel[store_count]),
                            exp_data[store_count] & lane_mask(exp_sel[store_count]));
                end else begin
                    $display("t=%0t the core stored %h to %h, which the program never does",
                             $time, wb_wdata, wb_adr);
                    errors++;
                end
                store_count <= store_count + 1;
            end
            if (halted) begin
                halt_seen <= 1'b1;
            end
            if (halted && wb_cyc) begin
                $display("t=%0t the core started a bus cycle after it halted", $time);
                errors++;
            end
        end
        if (active_q && !active) begin
            if (store_count != exp_count) begin
                $display("t=%0t the program should make %0d stores but the core made %0d",
                         $time, exp_count, store_count);
                errors++;
            end
            compare("halted", {31'd0, halt_seen}, {31'd0, exp_halt});
        end
        active_q <= active;
    end

endmodule

/* verification/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int rows = 5;
    localparam int prog_max = 24;
    localparam int data_max = 4;
    localparam int store_max = 8;
    localparam int halt_limit = 2000;  // cycles allowed before halted must rise.
    localparam int quiet_cycles = 12;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] wb_adr;
    logic [31:0] wb_wdata;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_rdata = '0;
    logic        wb_ack = 1'b0;
    logic        halted;

    logic [31:0] mem [0:255];
    int          seed = 22;
    int          ack_delay = 0;
    logic        busy = 1'b0;
    logic        active = 1'b0;
    int          tb_errors = 0;
    int          checker_errors;

    // one row per program.
    logic [31:0] prog [rows][prog_max];
    int          prog_len [rows];
    logic [31:0] init_adr [rows][data_max];
    logic [31:0] init_val [rows][data_max];
    int          init_len [rows];
    logic [31:0] st_adr [rows][store_max];
    logic [31:0] st_data [rows][store_max];
    logic [3:0]  st_sel [rows][store_max];
    int          st_len [rows];
    logic        st_halt [rows];

    logic [31:0] exp_adr [0:7];
    logic [31:0] exp_data [0:7];
    logic [3:0]  exp_sel [0:7];
    int          exp_count = 0;
    logic        exp_halt = 1'b0;

    always #4 clk = ~clk;

    rv_core i_rv_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_adr  (wb_adr),
        .wb_wdata(wb_wdata),
        .wb_sel  (wb_sel),
        .wb_we   (wb_we),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_rdata(wb_rdata),
        .wb_ack  (wb_ack),
        .halted  (halted)
    );

    rv_core_checker i_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .active     (active),
        .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),
        .wb_sel     (wb_sel),
        .wb_we      (wb_we),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_ack     (wb_ack),
        .halted     (halted),
        .exp_adr    (exp_adr),
        .exp_data   (exp_data),
        .exp_sel    (exp_sel),
        .exp_count  (exp_count),
        .exp_halt   (exp_halt),
        .error_count(checker_errors)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone slave with a random ack delay of 0 to 3 cycles per transfer.
    always @(negedge clk) begin
        if (!rst_n || wb_ack) begin
            wb_ack <= 1'b0;
            busy = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy = 1'b1;
                ack_delay = $unsigned($random(seed)) % 4;
            end
            if (ack_delay == 0) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_we && wb_sel[b]) begin
                        mem[wb_adr[9:2]][8*b +: 8] = wb_wdata[8*b +: 8];
                    end
                end
                wb_rdata <= mem[wb_adr[9:2]];
                wb_ack   <= 1'b1;
            end else begin
                ack_delay = ack_delay - 1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encoders for the rv32 layouts.
    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input int imm, input int rd, input int op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic put_inst(input int r, input logic [31:0] w);
        prog[r][prog_len[r]] = w;
        prog_len[r]++;
    endtask

    task automatic put_word(input int r, input logic [31:0] adr, input logic [31:0] val);
        init_adr[r][init_len[r]] = adr;
        init_val[r][init_len[r]] = val;
        init_len[r]++;
    endtask

    task automatic expect_store(input int r, input logic [31:0] adr, input logic [31:0] data,
                                input logic [3:0] sel);
        st_adr[r][st_len[r]]  = adr;
        st_data[r][st_len[r]] = data;
        st_sel[r][st_len[r]]  = sel;
        st_len[r]++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_table();
        int a;
        int b;
        logic [31:0] word0;
        logic [31:0] word1;
        a = 100;
        b = -7;
        word0 = 32'hcafe_f00d;
        word1 = 32'h1234_56f8;
        for (int r = 0; r < rows; r++) begin
            st_halt[r] = 1'b1;
        end
        // alu results go to 0x200 upward.
        put_inst(0, enc_i(a, 0, 0, 1, 'h13));
        put_inst(0, enc_i(b, 0, 0, 2, 'h13));
        put_inst(0, enc_r(0, 2, 1, 0, 3));
        put_inst(0, enc_r('h20, 2, 1, 0, 4));
        put_inst(0, enc_r(0, 2, 1, 4, 5));
        put_inst(0, enc_r(0, 2, 1, 6, 6));
        put_inst(0, enc_r(0, 1, 2, 3, 7));         // sltu x7 = x2 < x1.
        put_inst(0, enc_i(-1, 1, 3, 8, 'h13));     // sltiu against all ones.
        put_inst(0, enc_i('h401, 2, 5, 9, 'h13));  // srai by one.
        for (int k = 3; k <= 9; k++) begin
            put_inst(0, enc_s('h200 + 4 * (k - 3), k, 0, 2));
        end
        put_inst(0, ebreak_word);
        expect_store(0, 'h200, a + b, 4'hf);
        expect_store(0, 'h204, a - b, 4'hf);
        expect_store(0, 'h208, a ^ b, 4'hf);
        expect_store(0, 'h20c, a | b, 4'hf);
        expect_store(0, 'h210, 0, 4'hf);
        expect_store(0, 'h214, 1, 4'hf);
        expect_store(0, 'h218, b >>> 1, 4'hf);
        // branches. the stores at 16 and 40 sit on skipped paths.
        put_inst(1, enc_i(5, 0, 0, 1, 'h13));
        put_inst(1, enc_i(5, 0, 0, 2, 'h13));
        put_inst(1, enc_i(9, 0, 0, 3, 'h13));
        put_inst(1, enc_b(8, 2, 1, 0));
        put_inst(1, enc_s('h200, 1, 0, 2));
        put_inst(1, enc_b(8, 2, 1, 1));
        put_inst(1, enc_s('h204, 3, 0, 2));
        put_inst(1, enc_b(8, 3, 1, 0));
        put_inst(1, enc_s('h208, 2, 0, 2));
        put_inst(1, enc_b(8, 3, 1, 1));
        put_inst(1, enc_s('h20c, 1, 0, 2));
        put_inst(1, enc_s('h210, 3, 0, 2));
        put_inst(1, ebreak_word);
        expect_store(1, 'h204, 9, 4'hf);
        expect_store(1, 'h208, 5, 4'hf);
        expect_store(1, 'h210, 9, 4'hf);
        // jal at 0 and 28, jalr at 16 to the odd target 29.
        put_inst(2, enc_j(8, 1));
        put_inst(2, enc_s('h200, 0, 0, 2));
        put_inst(2, enc_s('h204, 1, 0, 2));
        put_inst(2, enc_i(29, 0, 0, 5, 'h13));
        put_inst(2, enc_i(0, 5, 0, 6, 'h67));
        put_inst(2, enc_s('h200, 0, 0, 2));
        put_inst(2, enc_s('h200, 0, 0, 2));
        put_inst(2, enc_j(8, 7));                  // a link of 33 would mean bit 0 stayed set.
        put_inst(2, enc_s('h200, 0, 0, 2));
        put_inst(2, enc_s('h208, 6, 0, 2));
        put_inst(2, enc_s('h20c, 7, 0, 2));
        put_inst(2, ebreak_word);
        expect_store(2, 'h204, 0 + 4, 4'hf);
        expect_store(2, 'h208, 16 + 4, 4'hf);
        expect_store(2, 'h20c, 28 + 4, 4'hf);
        // loads from preloaded words, then halfword stores to both halves.
        put_word(3, 'h240, word0);
        put_word(3, 'h244, word1);
        put_inst(3, enc_i('h240, 0, 2, 1, 'h03));
        put_inst(3, enc_i('h244, 0, 4, 2, 'h03));
        put_inst(3, enc_i('h242, 0, 4, 3, 'h03));
        put_inst(3, enc_s('h200, 1, 0, 2));
        put_inst(3, enc_s('h204, 2, 0, 2));
        put_inst(3, enc_s('h208, 3, 0, 2));
        put_inst(3, enc_s('h20c, 1, 0, 1));
        put_inst(3, enc_s('h212, 1, 0, 1));
        put_inst(3, ebreak_word);
        expect_store(3, 'h200, word0, 4'hf);
        expect_store(3, 'h204, {24'd0, word1[7:0]}, 4'hf);
        expect_store(3, 'h208, {24'd0, word0[23:16]}, 4'hf);
        expect_store(3, 'h20c, {16'd0, word0[15:0]}, 4'h3);
        expect_store(3, 'h212, {word0[15:0], 16'd0}, 4'hc);
        // auipc, then slli which lies outside the subset.
        put_inst(4, enc_u('h12345, 1, 'h17));
        put_inst(4, enc_u('hfffff, 2, 'h17));
        put_inst(4, enc_s('h200, 1, 0, 2));
        put_inst(4, enc_s('h204, 2, 0, 2));
        put_inst(4, enc_i(1, 1, 1, 3, 'h13));
        put_inst(4, enc_s('h208, 1, 0, 2));
        expect_store(4, 'h200, 0 + ('h12345 << 12), 4'hf);
        expect_store(4, 'h204, 4 + ('hfffff << 12), 4'hf);
    endtask

    task automatic run_row(input int r);
        int cycles;
        @(negedge clk);
        rst_n  = 1'b0;
        active = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h0bad_0000 | (i << 2);  // never a legal opcode.
        end
        for (int i = 0; i < prog_len[r]; i++) begin
            mem[i] = prog[r][i];
        end
        for (int i = 0; i < init_len[r]; i++) begin
            mem[init_adr[r][i][9:2]] = init_val[r][i];
        end
        for (int i = 0; i < store_max; i++) begin
            exp_adr[i]  = st_adr[r][i];
            exp_data[i] = st_data[r][i];
            exp_sel[i]  = st_sel[r][i];
        end
        exp_count = st_len[r];
        exp_halt  = st_halt[r];
        repeat (2) @(negedge clk);
        rst_n  = 1'b1;
        active = 1'b1;
        cycles = 0;
        while (!halted && cycles < halt_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted && st_halt[r]) begin
            $display("program %0d did not halt within %0d cycles", r, halt_limit);
            tb_errors++;
        end
        repeat (quiet_cycles) @(negedge clk);  // the bus must stay idle after the halt.
        active = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        build_table();
        for (int r = 0; r < rows; r++) begin
            run_row(r);
        end
        $display("error count: checker %0d, testbench %0d", checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* src.f */
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_next_pc.sv
hdl/rv_bus_ctrl.sv
hdl/rv_core.sv
verification/rv_core_checker.sv
verification/tb_rv_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f src.f -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$log"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
